// ==== Bender.yml ====
package:
  name: stream_pairer

dependencies: {}

sources:
  # Package first, then interface, then modules bottom up
  - files:
      - design/streamPkg.sv
      - design/laneReadIf.sv
      - design/laneMemory.sv
      - design/fifoLane.sv
      - design/pairCombiner.sv
      - design/streamPairer.sv

  - target: test
    files:
      - tests/streamPairerTb.sv

// ==== all.f ====
design/streamPkg.sv
design/laneReadIf.sv
design/laneMemory.sv
design/fifoLane.sv
design/pairCombiner.sv
design/streamPairer.sv
tests/streamPairerTb.sv

// ==== design/fifoLane.sv ====
`timescale 1ns/1ps

// Single-clock FIFO lane
module fifoLane #(
    parameter type payload_t = logic
) (
    input  logic     rdclk,
    input  logic     rst,

    // Write side
    input  logic     write,
    input  payload_t dataIn,
    output logic     almostFull,

    // Read side
    laneReadIf.lane  rd
);

    import streamPkg::*;

    laneAddr_t               writeAddr;
    laneAddr_t               readAddr;
    laneAddr_t               writesLeft;
    laneAddr_t               memReadAddr;
    logic                    isReading;
    logic [READ_LATENCY-1:0] validPipe;

    // Free slots, counting the gap in front of the read pointer
    assign writesLeft = readAddr - writeAddr;

    // Only the gap left means nothing to read
    assign rd.empty = writesLeft == laneAddr_t'((1 << DEPTH_LOG2) - 1);

    assign isReading = rd.readRequest && !rd.empty;

    // Pointers
    // Write side runs one slot ahead so the read head never sits on it
    always_ff @(posedge rdclk) begin
        if (rst) begin
            writeAddr <= laneAddr_t'(1);
            readAddr  <= '0;
        end else begin
            if (write) begin
                writeAddr <= writeAddr + 1'b1;
            end
            if (isReading) begin
                readAddr <= readAddr + 1'b1;
            end
        end
    end

    always_ff @(posedge rdclk) begin
        if (rst) begin
            almostFull <= 1'b0;
        end else begin
            almostFull <= writesLeft <= laneAddr_t'(ALMOST_FULL_MARGIN);
        end
    end

    // Valid follows the memory latency
    always_ff @(posedge rdclk) begin
        if (rst) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= isReading;
            for (int i = 1; i < READ_LATENCY; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    assign rd.dataOutValid = validPipe[READ_LATENCY-1];

    // Point at the last slot read when idle, keeps dataOut steady
    assign memReadAddr = isReading ? readAddr + 1'b1 : readAddr;

    laneMemory #(
        .payload_t (payload_t)
    ) laneMemory_i (
        .rdclk       (rdclk),
        .writeEnable (write),
        .writeAddr   (writeAddr),
        .dataIn      (dataIn),
        .readAddr    (memReadAddr),
        .dataOut     (rd.dataOut)
    );

    // Writer must have stopped on almostFull long before this
    noWriteWhenFull: assert property (
        @(posedge rdclk) disable iff (rst)
        write |-> writesLeft != '0
    ) else $error("fifoLane write into a full lane");

endmodule

// ==== design/laneMemory.sv ====
`timescale 1ns/1ps

// Simple dual-port memory, one write port and one read port
module laneMemory #(
    parameter type payload_t = logic
) (
    input  logic                 rdclk,

    // Write port
    input  logic                 writeEnable,
    input  streamPkg::laneAddr_t writeAddr,
    input  payload_t             dataIn,

    // Read port, two cycles from address to data
    input  streamPkg::laneAddr_t readAddr,
    output payload_t             dataOut
);

    import streamPkg::*;

    payload_t  mem [0:(1 << DEPTH_LOG2)-1];
    laneAddr_t readAddrReg;

    always_ff @(posedge rdclk) begin
        if (writeEnable) begin
            mem[writeAddr] <= dataIn;
        end
    end

    // Registered address
    always_ff @(posedge rdclk) begin
        readAddrReg <= readAddr;
    end

    // Registered output
    // Read during write returns the old word
    always_ff @(posedge rdclk) begin
        dataOut <= mem[readAddrReg];
    end

endmodule

// ==== design/laneReadIf.sv ====
`timescale 1ns/1ps

// Read side of one FIFO lane
interface laneReadIf #(
    parameter type payload_t = logic
);

    logic     readRequest;
    logic     empty;
    payload_t dataOut;
    logic     dataOutValid;

    // FIFO side
    modport lane (
        input  readRequest,
        output empty,
        output dataOut,
        output dataOutValid
    );

    // Consumer side
    modport reader (
        output readRequest,
        input  empty,
        input  dataOut,
        input  dataOutValid
    );

endinterface

// ==== design/pairCombiner.sv ====
`timescale 1ns/1ps

// Reads both lanes together and holds one pair for the consumer
module pairCombiner (
    input  logic               rdclk,
    input  logic               rst,

    // Lane read sides
    laneReadIf.reader          laneA,
    laneReadIf.reader          laneB,

    // Consumer side
    input  logic               pairGrab,
    output logic               pairAvailable,
    output streamPkg::sample_t pairOutA,
    output streamPkg::tag_t    pairOutB
);

    import streamPkg::*;

    logic    grab;
    logic    bothReady;
    logic    issueRead;
    logic    inFlight;

    // A grab with nothing held does nothing
    assign grab = pairGrab && pairAvailable;

    assign bothReady = !laneA.empty && !laneB.empty;

    // One read at a time
    // A second read could land on top of an unclaimed first one
    assign issueRead = bothReady && !inFlight && (!pairAvailable || grab);

    assign laneA.readRequest = issueRead;
    assign laneB.readRequest = issueRead;

    // Both lanes share the latency, so lane A's valid stands for both
    always_ff @(posedge rdclk) begin
        if (rst) begin
            inFlight <= 1'b0;
        end else if (issueRead) begin
            inFlight <= 1'b1;
        end else if (laneA.dataOutValid) begin
            inFlight <= 1'b0;
        end
    end

    // Valid and grab never meet, the slot is empty when data lands
    always_ff @(posedge rdclk) begin
        if (rst) begin
            pairAvailable <= 1'b0;
        end else if (laneA.dataOutValid) begin
            pairAvailable <= 1'b1;
        end else if (grab) begin
            pairAvailable <= 1'b0;
        end
    end

    // Held pair
    always_ff @(posedge rdclk) begin
        if (laneA.dataOutValid) begin
            pairOutA <= laneA.dataOut;
            pairOutB <= laneB.dataOut;
        end
    end

    // Lanes were read in the same cycle, so their data must land together
    validsCoincide: assert property (
        @(posedge rdclk) disable iff (rst)
        laneA.dataOutValid == laneB.dataOutValid
    ) else $error("pairCombiner lane valids out of step");

    // Held pair only changes on a grab
    holdUntilGrab: assert property (
        @(posedge rdclk) disable iff (rst)
        pairAvailable && !pairGrab |=>
            pairAvailable && $stable(pairOutA) && $stable(pairOutB)
    ) else $error("pairCombiner output changed without a grab");

endmodule

// ==== design/streamPairer.sv ====
`timescale 1ns/1ps

// Two independent write streams paired up for one consumer
module streamPairer (
    input  logic               rdclk,
    input  logic               rst,

    // Stream A, samples
    input  logic               writeA,
    input  streamPkg::sample_t dataA,
    output logic               almostFullA,

    // Stream B, tags
    input  logic               writeB,
    input  streamPkg::tag_t    dataB,
    output logic               almostFullB,

    // Paired output
    input  logic               pairGrab,
    output logic               pairAvailable,
    output streamPkg::sample_t pairOutA,
    output streamPkg::tag_t    pairOutB
);

    import streamPkg::*;

    laneReadIf #(.payload_t(sample_t)) laneAIf ();
    laneReadIf #(.payload_t(tag_t))    laneBIf ();

    // Lane A
    fifoLane #(
        .payload_t (sample_t)
    ) fifoLaneA_i (
        .rdclk      (rdclk),
        .rst        (rst),
        .write      (writeA),
        .dataIn     (dataA),
        .almostFull (almostFullA),
        .rd         (laneAIf.lane)
    );

    // Lane B
    fifoLane #(
        .payload_t (tag_t)
    ) fifoLaneB_i (
        .rdclk      (rdclk),
        .rst        (rst),
        .write      (writeB),
        .dataIn     (dataB),
        .almostFull (almostFullB),
        .rd         (laneBIf.lane)
    );

    // Lockstep reader with the held output pair
    pairCombiner pairCombiner_i (
        .rdclk         (rdclk),
        .rst           (rst),
        .laneA         (laneAIf.reader),
        .laneB         (laneBIf.reader),
        .pairGrab      (pairGrab),
        .pairAvailable (pairAvailable),
        .pairOutA      (pairOutA),
        .pairOutB      (pairOutB)
    );

endmodule

// ==== design/streamPkg.sv ====
package streamPkg;

    // Lane geometry
    // 16 slots, one is always kept open by the write pointer offset
    localparam int DEPTH_LOG2 = 4;

    // Free entries at or below which a lane raises almostFull
    localparam int ALMOST_FULL_MARGIN = 4;

    // Accepted read request to dataOutValid
    // One cycle for the address register, one for the output register
    localparam int READ_LATENCY = 2;

    // Lane A payload, one sample
    typedef logic [15:0] sample_t;

    // Lane B payload, one tag
    typedef logic [7:0] tag_t;

    // Pointer into a lane memory
    // Wraps naturally at the lane depth
    typedef logic [DEPTH_LOG2-1:0] laneAddr_t;

endpackage

// ==== tests/streamPairerTb.sv ====
`timescale 1ns/1ps

module streamPairerTb;

    import streamPkg::*;

    logic    rdclk;
    logic    rst;
    logic    writeA;
    sample_t dataA;
    logic    almostFullA;
    logic    writeB;
    tag_t    dataB;
    logic    almostFullB;
    logic    pairGrab;
    logic    pairAvailable;
    sample_t pairOutA;
    tag_t    pairOutB;

    integer  seed = 32'hc000;

    // Reference model of what each lane still owes the consumer
    sample_t laneAModel [$];
    tag_t    laneBModel [$];
    int      sizeA = 0;
    int      sizeB = 0;
    sample_t headA = '0;
    tag_t    headB = '0;

    logic    quietWindow = 1'b0;
    int      errorCount = 0;
    int      testsRun = 0;
    int      testsFailed = 0;
    int      errorsAtStart = 0;
    string   testName;

    streamPairer streamPairer_i (
        .rdclk         (rdclk),
        .rst           (rst),
        .writeA        (writeA),
        .dataA         (dataA),
        .almostFullA   (almostFullA),
        .writeB        (writeB),
        .dataB         (dataB),
        .almostFullB   (almostFullB),
        .pairGrab      (pairGrab),
        .pairAvailable (pairAvailable),
        .pairOutA      (pairOutA),
        .pairOutB      (pairOutB)
    );

    initial begin
        rdclk = 1'b0;
    end

    always #10 rdclk = ~rdclk;

    // Model follows the DUT's accepted writes and grabs
    always @(posedge rdclk) begin
        if (rst) begin
            laneAModel.delete();
            laneBModel.delete();
        end else begin
            if (pairGrab && pairAvailable) begin
                if (laneAModel.size() > 0) begin
                    void'(laneAModel.pop_front());
                end
                if (laneBModel.size() > 0) begin
                    void'(laneBModel.pop_front());
                end
            end
            if (writeA) begin
                laneAModel.push_back(dataA);
            end
            if (writeB) begin
                laneBModel.push_back(dataB);
            end
        end
        sizeA = laneAModel.size();
        sizeB = laneBModel.size();
        headA = (sizeA > 0) ? laneAModel[0] : '0;
        headB = (sizeB > 0) ? laneBModel[0] : '0;
    end

    task automatic reportMismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        errorCount++;
    endtask

    task automatic reportTimeout(input string what, input int limit);
        $display("timeout at %0t: %s did not happen within %0d cycles", $time, what, limit);
        errorCount++;
    endtask

    task automatic startTest(input string name);
        testName = name;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest();
        testsRun++;
        if (errorCount != errorsAtStart) begin
            testsFailed++;
            $display("%s: FAILED with %0d errors", testName, errorCount - errorsAtStart);
        end else begin
            $display("%s: passed", testName);
        end
    endtask

    // Called at a falling edge, holds the inputs for one full cycle
    task automatic driveCycle(input logic wantA, input logic wantB, input logic wantGrab);
        writeA   = wantA && !almostFullA;
        dataA    = 16'($random(seed));
        writeB   = wantB && !almostFullB;
        dataB    = 8'($random(seed));
        pairGrab = wantGrab;
        @(negedge rdclk);
    endtask

    task automatic waitForPair(input int limit, input string what);
        int cycles;
        cycles = 0;
        while (!pairAvailable && cycles < limit) begin
            driveCycle(1'b0, 1'b0, 1'b0);
            cycles++;
        end
        if (!pairAvailable) begin
            reportTimeout(what, limit);
        end
    endtask

    // Even out both lanes, then grab until the model is empty
    task automatic balanceAndDrain(input int limit);
        int cycles;
        cycles = 0;
        while (sizeA != sizeB && cycles < limit) begin
            driveCycle(sizeA < sizeB, sizeB < sizeA, 1'b1);
            cycles++;
        end
        if (sizeA != sizeB) begin
            reportTimeout("balancing both lanes", limit);
        end
        cycles = 0;
        while ((sizeA != 0 || sizeB != 0) && cycles < limit) begin
            driveCycle(1'b0, 1'b0, 1'b1);
            cycles++;
        end
        if (sizeA != 0 || sizeB != 0) begin
            reportTimeout("draining both lanes", limit);
        end
        repeat (4) driveCycle(1'b0, 1'b0, 1'b0);
    endtask

    resetQuiet: assert property (
        @(posedge rdclk) quietWindow |-> !pairAvailable && !almostFullA && !almostFullB
    ) else reportMismatch("outputs not idle around reset");

    // Grabbed pair must be the oldest write of each lane
    pairOrder: assert property (
        @(posedge rdclk) disable iff (rst)
        pairGrab && pairAvailable |-> pairOutA == headA && pairOutB == headB
    ) else reportMismatch($sformatf("pair %h/%h, expected %h/%h",
                                    pairOutA, pairOutB, headA, headB));

    noPairFromEmptyLane: assert property (
        @(posedge rdclk) disable iff (rst)
        sizeA == 0 || sizeB == 0 |-> !pairAvailable
    ) else reportMismatch("pairAvailable with a lane owing nothing");

    holdWithoutGrab: assert property (
        @(posedge rdclk) disable iff (rst)
        pairAvailable && !pairGrab |=>
            pairAvailable && $stable(pairOutA) && $stable(pairOutB)
    ) else reportMismatch("held pair changed without a grab");

    // At most one pair sits outside the lanes, so sizeX - 1 bounds the stored count
    almostFullRisesA: assert property (
        @(posedge rdclk) disable iff (rst)
        sizeA - 1 >= 15 - ALMOST_FULL_MARGIN |=> almostFullA
    ) else reportMismatch("almostFullA low with lane A nearly full");

    almostFullRisesB: assert property (
        @(posedge rdclk) disable iff (rst)
        sizeB - 1 >= 15 - ALMOST_FULL_MARGIN |=> almostFullB
    ) else reportMismatch("almostFullB low with lane B nearly full");

    almostFullLowA: assert property (
        @(posedge rdclk) disable iff (rst)
        sizeA < 15 - ALMOST_FULL_MARGIN |=> !almostFullA
    ) else reportMismatch("almostFullA high with room left in lane A");

    almostFullLowB: assert property (
        @(posedge rdclk) disable iff (rst)
        sizeB < 15 - ALMOST_FULL_MARGIN |=> !almostFullB
    ) else reportMismatch("almostFullB high with room left in lane B");

    initial begin
        int   cycles;
        int   delay;
        logic [31:0] r;

        rst      = 1'b1;
        writeA   = 1'b0;
        dataA    = '0;
        writeB   = 1'b0;
        dataB    = '0;
        pairGrab = 1'b0;

        startTest("reset state");
        repeat (2) @(negedge rdclk);
        quietWindow = 1'b1;
        repeat (8) @(negedge rdclk);
        rst = 1'b0;
        repeat (6) driveCycle(1'b0, 1'b0, 1'b0);
        quietWindow = 1'b0;
        finishTest();

        startTest("pairing order");
        repeat (300) begin
            r = $random(seed);
            driveCycle(r[1:0] != 2'b00, r[3:2] != 2'b00, r[5]);
        end
        balanceAndDrain(200);
        finishTest();

        // Lane B starved while lane A fills up
        startTest("unbalanced streams");
        repeat (40) begin
            r = $random(seed);
            driveCycle(1'b1, 1'b0, r[0]);
        end
        driveCycle(1'b0, 1'b1, 1'b0);
        waitForPair(20, "pair after the first lane B write");
        balanceAndDrain(200);
        finishTest();

        startTest("hold under back-pressure");
        repeat (4) driveCycle(1'b1, 1'b1, 1'b0);
        repeat (4) begin
            waitForPair(20, "next held pair");
            delay = 1 + ($random(seed) & 7);
            repeat (delay) driveCycle(1'b0, 1'b0, 1'b0);
            driveCycle(1'b0, 1'b0, 1'b1);
        end
        balanceAndDrain(200);
        finishTest();

        startTest("almost-full");
        cycles = 0;
        while (!(almostFullA && almostFullB) && cycles < 80) begin
            r = $random(seed);
            driveCycle(r[0] | r[1], r[2] | r[3], 1'b0);
            cycles++;
        end
        if (!(almostFullA && almostFullB)) begin
            reportTimeout("almostFull on both lanes", 80);
        end
        // Writers keep asking, almostFull holds them back
        repeat (10) driveCycle(1'b1, 1'b1, 1'b0);
        finishTest();

        startTest("drain");
        balanceAndDrain(200);
        repeat (10) driveCycle(1'b0, 1'b0, 1'b0);
        finishTest();

        $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
